//--- source/sm83_alu_ops_pkg.sv
package sm83_alu_ops_pkg;

	// ########################################
	// opcodes
	// ########################################

	// same order as bits 5:3 of the SM83 8-bit ALU instructions
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_ADC = 3'd1,
		ALU_SUB = 3'd2,
		ALU_SBC = 3'd3,
		ALU_AND = 3'd4,
		ALU_XOR = 3'd5,
		ALU_OR  = 3'd6,
		ALU_CP  = 3'd7
	} alu_op_e;

	// ########################################
	// request
	// ########################################

	// one ALU request as pushed from upstream, 20 bits
	typedef struct packed {
		alu_op_e    op;
		logic [7:0] a;        // accumulator side
		logic [7:0] b;        // register or immediate side
		logic       carry_in; // the C flag before the instruction, read by ADC and SBC
	} alu_req_t;

endpackage

//--- source/sm83_alu_flags_pkg.sv
package sm83_alu_flags_pkg;

	// ########################################
	// flag byte
	// ########################################

	// laid out like the F register, z in bit 7 down to c in bit 4
	typedef struct packed {
		logic       z;
		logic       n;
		logic       h;
		logic       c;
		logic [3:0] zero; // low nibble of F always reads back as zero
	} alu_flags_t;

	// ########################################
	// result
	// ########################################

	// value in the upper byte and flags in the lower, like an AF pair
	typedef struct packed {
		logic [7:0] value;
		alu_flags_t flags;
	} alu_res_t;

endpackage

//--- source/sm83_alu_pggen.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu_pggen (
	input  logic xor_in1,
	input  logic xor_in2,
	input  logic and_or_in2,
	input  logic ao221_in2,
	input  logic ao221_in3,
	input  logic ao221_in5_n,
	output logic tap_xor,
	output logic tap_nand,
	output logic tap_and,
	output logic tap_or,
	output logic y
);

	// operand conditioning, xor_in2 high inverts xor_in1
	assign tap_xor = xor_in1 ^ xor_in2;

	// taps against the second operand
	assign tap_nand = ~(tap_xor & and_or_in2);
	assign tap_and  = ~tap_nand; // generate when used as an adder slice
	assign tap_or   = tap_xor | and_or_in2; // propagate when used as an adder slice

	// and-or stage, with ao221_in3 as carry in this is g | (p & c)
	// an active low ao221_in5_n forces y high
	assign y = (tap_and & ao221_in2) | (ao221_in3 & tap_or) | ~ao221_in5_n;

endmodule

`default_nettype wire

//--- source/sm83_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu_core (
	input  sm83_alu_ops_pkg::alu_req_t   req,
	output sm83_alu_flags_pkg::alu_res_t res
);

	logic       sub;       // subtract family, b goes in inverted
	logic       logic_op;
	logic       cin;       // carry into bit 0
	logic [8:0] carry;     // carry[i] enters bit i
	logic [7:0] tap_xor;
	logic [7:0] tap_nand;
	logic [7:0] tap_and;
	logic [7:0] tap_or;
	logic [7:0] y;
	logic [7:0] sum;
	logic [7:0] alu_val;

	assign sub = (req.op == sm83_alu_ops_pkg::ALU_SUB) ||
	             (req.op == sm83_alu_ops_pkg::ALU_SBC) ||
	             (req.op == sm83_alu_ops_pkg::ALU_CP);

	assign logic_op = (req.op == sm83_alu_ops_pkg::ALU_AND) ||
	                  (req.op == sm83_alu_ops_pkg::ALU_XOR) ||
	                  (req.op == sm83_alu_ops_pkg::ALU_OR);

	// ########################################
	// carry in and slices
	// ########################################

	// subtraction runs as a + ~b + 1, so SBC takes the inverted carry flag
	always_comb begin
		case (req.op)
			sm83_alu_ops_pkg::ALU_ADC: cin = req.carry_in;
			sm83_alu_ops_pkg::ALU_SUB: cin = 1'b1;
			sm83_alu_ops_pkg::ALU_CP:  cin = 1'b1;
			sm83_alu_ops_pkg::ALU_SBC: cin = ~req.carry_in;
			default:                   cin = 1'b0;
		endcase
	end

	assign carry[0] = cin;

	for (genvar i = 0; i < 8; i++) begin : g_slice
		sm83_alu_pggen pggen_i (
			.xor_in1     (req.b[i]),
			.xor_in2     (sub),
			.and_or_in2  (req.a[i]),
			.ao221_in2   (1'b1),
			.ao221_in3   (carry[i]),
			.ao221_in5_n (1'b1),
			.tap_xor     (tap_xor[i]),
			.tap_nand    (tap_nand[i]),
			.tap_and     (tap_and[i]),
			.tap_or      (tap_or[i]),
			.y           (y[i])
		);

		assign carry[i+1] = y[i]; // ripple through the and-or stage
		assign sum[i]     = req.a[i] ^ tap_xor[i] ^ carry[i];
	end

	// ########################################
	// result select and flags
	// ########################################

	always_comb begin
		case (req.op)
			sm83_alu_ops_pkg::ALU_AND: alu_val = tap_and;
			sm83_alu_ops_pkg::ALU_XOR: alu_val = tap_or & tap_nand; // set where exactly one is set
			sm83_alu_ops_pkg::ALU_OR:  alu_val = tap_or;
			default:                   alu_val = sum;
		endcase
	end

	always_comb begin
		// CP only compares, the accumulator comes back unchanged
		res.value = (req.op == sm83_alu_ops_pkg::ALU_CP) ? req.a : alu_val;

		res.flags.z = (alu_val == 8'h00);
		res.flags.n = sub;

		if (logic_op) begin
			res.flags.h = (req.op == sm83_alu_ops_pkg::ALU_AND);
			res.flags.c = 1'b0;
		end else begin
			// a missing carry out is a borrow when subtracting
			res.flags.h = carry[4] ^ sub;
			res.flags.c = carry[8] ^ sub;
		end

		res.flags.zero = 4'h0;
	end

endmodule

`default_nettype wire

//--- source/sm83_alu_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu_req_queue #(
	parameter int REQ_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req_valid,
	input  sm83_alu_ops_pkg::alu_req_t req,
	input  logic                       res_space,
	output sm83_alu_ops_pkg::alu_req_t head,
	output logic                       head_valid,
	output logic                       pop,
	output logic                       req_credit
);

	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1);

	sm83_alu_ops_pkg::alu_req_t mem [REQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign head       = mem[rd_ptr];
	assign head_valid = (count != '0);
	assign pop        = head_valid && res_space; // the only place the pop decision is made

	// upstream holds a credit for every push, so no full check here
	always_ff @(posedge clk) begin
		if (req_valid) begin
			mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			req_credit <= 1'b0;
		end else begin
			if (req_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end

			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			case ({req_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			req_credit <= pop; // one credit back per freed entry
		end
	end

endmodule

`default_nettype wire

//--- source/sm83_alu_result_port.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu_result_port #(
	parameter int RES_DEPTH   = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         pop,
	input  sm83_alu_flags_pkg::alu_res_t result,
	input  logic                         res_credit,
	output logic                         res_space,
	output logic                         res_valid,
	output sm83_alu_flags_pkg::alu_res_t res
);

	localparam int PTR_W  = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
	localparam int CNT_W  = $clog2(RES_DEPTH + 1);
	localparam int CRED_W = $clog2(RES_CREDITS + 1);

	sm83_alu_flags_pkg::alu_res_t buf_mem [RES_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [CRED_W-1:0] credits;
	logic              send;

	assign send      = (count != '0) && (credits != '0);
	assign res_space = (count != CNT_W'(RES_DEPTH)) || send; // a full buffer that sends frees a slot

	always_ff @(posedge clk) begin
		if (pop) begin
			buf_mem[wr_ptr] <= result;
		end
		if (send) begin
			res <= buf_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= CRED_W'(RES_CREDITS);
			res_valid <= 1'b0;
		end else begin
			if (pop) begin
				wr_ptr <= (wr_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= (rd_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			case ({pop, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			case ({send, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // spend and return cancel out
			endcase

			res_valid <= send;
		end
	end

endmodule

`default_nettype wire

//--- source/sm83_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_alu_top #(
	parameter int REQ_DEPTH   = 4,
	parameter int RES_DEPTH   = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         req_valid,
	input  sm83_alu_ops_pkg::alu_req_t   req,
	input  logic                         res_credit,
	output logic                         req_credit,
	output logic                         res_valid,
	output sm83_alu_flags_pkg::alu_res_t res
);

	sm83_alu_ops_pkg::alu_req_t   head;
	sm83_alu_ops_pkg::alu_req_t   core_req;
	sm83_alu_flags_pkg::alu_res_t core_res;
	logic                         head_valid;
	logic                         pop;
	logic                         res_space;

	sm83_alu_req_queue #(
		.REQ_DEPTH (REQ_DEPTH)
	) req_queue_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.res_space  (res_space),
		.head       (head),
		.head_valid (head_valid),
		.pop        (pop),
		.req_credit (req_credit)
	);

	// keep the core inputs quiet while the queue is empty
	assign core_req = head_valid ? head : '0;

	sm83_alu_core core_i (
		.req (core_req),
		.res (core_res)
	);

	sm83_alu_result_port #(
		.RES_DEPTH   (RES_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) result_port_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.pop        (pop),
		.result     (core_res),
		.res_credit (res_credit),
		.res_space  (res_space),
		.res_valid  (res_valid),
		.res        (res)
	);

endmodule

`default_nettype wire

//--- tests/sm83_alu_ref.svh
`ifndef SM83_ALU_REF_SVH
`define SM83_ALU_REF_SVH

// ########################################
// reference model
// ########################################

// value entering bit 0 on top of the operands, a carry for ADC and a borrow for SBC
function automatic int carry_of(input sm83_alu_ops_pkg::alu_req_t r);
	if (r.op == sm83_alu_ops_pkg::ALU_ADC || r.op == sm83_alu_ops_pkg::ALU_SBC) begin
		return int'(r.carry_in);
	end
	return 0;
endfunction

// plain integer arithmetic with the SM83 flag rules on top
function automatic sm83_alu_flags_pkg::alu_res_t ref_result(input sm83_alu_ops_pkg::alu_req_t r);
	sm83_alu_flags_pkg::alu_res_t out;
	int a;
	int b;
	int k;
	int full;
	out = '0;
	a = int'(r.a);
	b = int'(r.b);
	k = carry_of(r);
	case (r.op)
		sm83_alu_ops_pkg::ALU_ADD, sm83_alu_ops_pkg::ALU_ADC: begin
			full = a + b + k;
			out.value = full[7:0];
			out.flags.h = ((a % 16) + (b % 16) + k) > 15; // carry out of the low nibble
			out.flags.c = full > 255;
		end
		sm83_alu_ops_pkg::ALU_SUB, sm83_alu_ops_pkg::ALU_SBC, sm83_alu_ops_pkg::ALU_CP: begin
			full = a - b - k;
			out.value = full[7:0];
			out.flags.n = 1'b1;
			out.flags.h = (a % 16) < ((b % 16) + k); // borrow from bit 4
			out.flags.c = full < 0;
		end
		sm83_alu_ops_pkg::ALU_AND: begin
			out.value = r.a & r.b;
			out.flags.h = 1'b1;
		end
		sm83_alu_ops_pkg::ALU_XOR: out.value = r.a ^ r.b;
		default:                   out.value = r.a | r.b;
	endcase
	out.flags.z = (out.value == 8'h00);
	// compare leaves the accumulator alone but keeps the subtract flags
	if (r.op == sm83_alu_ops_pkg::ALU_CP) begin
		out.value = r.a;
	end
	return out;
endfunction

`endif

//--- tests/tb_sm83_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sm83_alu;

	`include "sm83_alu_ref.svh"

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int QUIET_DELAY = 25; // a point in the cycle where no other process acts
	localparam int SEED        = 42140;

	localparam int REQ_DEPTH   = 4;
	localparam int RES_DEPTH   = 2;
	localparam int RES_CREDITS = 2;

	localparam int N_DIRECTED = 11;
	localparam int N_RANDOM   = 200;
	localparam int N_STALL    = REQ_DEPTH + RES_DEPTH + RES_CREDITS + 4; // more than the pipe holds
	localparam int N_REQUESTS = N_DIRECTED + N_RANDOM + N_STALL;

	logic                         clk;
	logic                         arst_n;
	logic                         req_valid;
	sm83_alu_ops_pkg::alu_req_t   req;
	logic                         res_credit;
	logic                         req_credit;
	logic                         res_valid;
	sm83_alu_flags_pkg::alu_res_t res;

	sm83_alu_flags_pkg::alu_res_t exp_q [$];
	sm83_alu_flags_pkg::alu_res_t exp_head;

	int up_credits;   // upstream side of the request credit loop
	int owed;         // results taken but not yet credited back
	int granted;
	int sends;
	bit pushed_any;
	bit hold_credit;

	sm83_alu_top #(
		.REQ_DEPTH   (REQ_DEPTH),
		.RES_DEPTH   (RES_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.res_credit (res_credit),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ########################################
	// helpers
	// ########################################

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] got, input logic [7:0] want);
		fail_run($sformatf("MISMATCH time %0t signal %s got 0x%02h expected 0x%02h",
			$time, name, got, want));
	endtask

	function automatic sm83_alu_ops_pkg::alu_req_t make_req(input sm83_alu_ops_pkg::alu_op_e op,
		input logic [7:0] a, input logic [7:0] b, input logic cin);
		sm83_alu_ops_pkg::alu_req_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		r.carry_in = cin;
		return r;
	endfunction

	function automatic sm83_alu_ops_pkg::alu_req_t random_req();
		sm83_alu_ops_pkg::alu_req_t r;
		r.op = sm83_alu_ops_pkg::alu_op_e'(3'($urandom % 8));
		r.a = 8'($urandom);
		r.b = 8'($urandom);
		r.carry_in = 1'($urandom);
		return r;
	endfunction

	// called and returns at DRIVE_DELAY after a rising edge
	task automatic push_req(input sm83_alu_ops_pkg::alu_req_t r);
		while (up_credits == 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		req_valid = 1'b1;
		req = r;
		up_credits--;
		exp_q.push_back(ref_result(r));
		pushed_any = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || owed != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk); // let the last credit reach the result port
		#DRIVE_DELAY;
	endtask

	// ########################################
	// checks
	// ########################################

	// nothing may come back before anything went in
	assert property (@(posedge clk) disable iff (!arst_n) !pushed_any |-> (!req_credit && !res_valid))
		else fail_run("req_credit or res_valid pulsed before the first request was pushed");

	always @(negedge clk) begin
		if (arst_n) begin
			if (req_credit) begin
				up_credits++;
				assert (up_credits <= REQ_DEPTH)
					else fail_run($sformatf("upstream holds %0d credits, more than REQ_DEPTH %0d",
						up_credits, REQ_DEPTH));
			end
			if (res_credit) begin
				granted++;
			end
			if (res_valid) begin
				sends++;
				assert (sends <= RES_CREDITS + granted)
					else fail_run($sformatf("result %0d was sent with only %0d credits granted",
						sends, RES_CREDITS + granted));
				assert (exp_q.size() > 0)
					else fail_run("a result arrived with no request outstanding");
				exp_head = exp_q.pop_front();
				assert (res.value === exp_head.value)
					else report_mismatch("res.value", res.value, exp_head.value);
				assert (res.flags === exp_head.flags)
					else report_mismatch("res.flags", res.flags, exp_head.flags);
				owed++;
			end
		end
	end

	// downstream hands back one credit per result, at random moments
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (arst_n && !hold_credit && owed > 0 && ($urandom % 2 == 1)) begin
			res_credit = 1'b1;
			owed--;
		end else begin
			res_credit = 1'b0;
		end
	end

	initial begin
		repeat (2000 * N_REQUESTS) @(posedge clk);
		fail_run("watchdog expired before every request completed");
	end

	// ########################################
	// stimulus
	// ########################################

	task automatic run_directed();
		push_req(make_req(sm83_alu_ops_pkg::ALU_ADD, 8'h0F, 8'h01, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_SUB, 8'h00, 8'h01, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_ADD, 8'hFF, 8'h01, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_ADC, 8'h0E, 8'h01, 1'b1));
		push_req(make_req(sm83_alu_ops_pkg::ALU_SBC, 8'h10, 8'h0F, 1'b1));
		push_req(make_req(sm83_alu_ops_pkg::ALU_AND, 8'hF0, 8'h0F, 1'b1));
		push_req(make_req(sm83_alu_ops_pkg::ALU_XOR, 8'h5A, 8'h5A, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_OR,  8'h00, 8'h00, 1'b1));
		push_req(make_req(sm83_alu_ops_pkg::ALU_OR,  8'h50, 8'h05, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_CP,  8'h3C, 8'h40, 1'b0));
		push_req(make_req(sm83_alu_ops_pkg::ALU_CP,  8'h42, 8'h42, 1'b1));
	endtask

	task automatic run_random();
		for (int i = 0; i < N_RANDOM; i++) begin
			push_req(random_req());
			if ($urandom % 4 == 0) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
	endtask

	// withhold downstream credit until the whole pipe backs up
	task automatic run_stall();
		#(QUIET_DELAY - DRIVE_DELAY);
		hold_credit = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		fork
			begin
				for (int i = 0; i < N_STALL; i++) begin
					push_req(random_req());
				end
			end
			begin
				repeat (40) @(posedge clk);
				#QUIET_DELAY;
				assert (up_credits == 0)
					else fail_run("upstream kept request credits while downstream credit was withheld");
				hold_credit = 1'b0;
			end
		join
	endtask

	initial begin
		void'($urandom(SEED));
		arst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		res_credit = 1'b0;
		up_credits = REQ_DEPTH;
		owed = 0;
		granted = 0;
		sends = 0;
		pushed_any = 1'b0;
		hold_credit = 1'b0;

		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		repeat (6) @(posedge clk); // idle window after reset
		#DRIVE_DELAY;

		run_directed();
		run_random();
		wait_drain();
		run_stall();
		wait_drain();

		// an idle DUT has handed every request credit back
		if (up_credits == REQ_DEPTH) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_run($sformatf("only %0d of %0d request credits came back at the end of the run",
				up_credits, REQ_DEPTH));
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
source/sm83_alu_ops_pkg.sv
source/sm83_alu_flags_pkg.sv
source/sm83_alu_pggen.sv
source/sm83_alu_core.sv
source/sm83_alu_req_queue.sv
source/sm83_alu_result_port.sv
source/sm83_alu_top.sv
tests/tb_sm83_alu.sv
